//--- hdl/mrelbp_cfg.svh
`ifndef MRELBP_CFG_SVH
`define MRELBP_CFG_SVH

// samples per window and width of one sample.
`define MRELBP_TAPS 17
`define MRELBP_PIX_W 8

// frame geometry in windows.
`define MRELBP_COLS 19
`define MRELBP_ROWS 19

`define MRELBP_CENTER_TAP 0

// 361 x 255 fits in 17 bits, 17 lanes of that fit in 21 bits.
`define MRELBP_LANE_W 17
`define MRELBP_SUM_W 21

// rows x cols x taps.
`define MRELBP_DIVISOR 6137
`define MRELBP_REM_W 13

`endif

//--- hdl/mrelbp_pkg.sv
`default_nettype none

`include "mrelbp_cfg.svh"

package mrelbp_pkg;

    // one sample window, tap 0 in the low byte.
    typedef struct packed {
        logic [`MRELBP_TAPS-1:0][`MRELBP_PIX_W-1:0] taps;
    } window_t;

    typedef enum logic {
        CTRL_IDLE,   // next window is window 0.
        CTRL_ACCUM
    } ctrl_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_SHIFT,
        DIV_DONE
    } div_state_e;

    typedef struct packed {
        logic [`MRELBP_PIX_W-1:0] muy;   // quotient, low byte.
        logic [`MRELBP_REM_W-1:0] r;
    } mean_t;

endpackage

`default_nettype wire

//--- hdl/ci_frame_ctrl.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module ci_frame_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  logic win_valid_i,
    output logic clear_o,
    output logic accum_o,
    output logic center_o,
    output logic row_done_o,
    output logic frame_end_o
);

    localparam int COLS  = `MRELBP_COLS;
    localparam int ROWS  = `MRELBP_ROWS;
    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    mrelbp_pkg::ctrl_state_e state_q;

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             last_col;
    logic             last_row;
    logic             last_win;
    logic             at_center;
    logic             end_pend_q;   // last window is in its accumulate cycle.

    assign last_col  = (col_q == COL_W'(COLS - 1));
    assign last_row  = (row_q == ROW_W'(ROWS - 1));
    assign last_win  = last_col && last_row;
    assign at_center = (row_q == ROW_W'(ROWS / 2)) && (col_q == COL_W'(COLS / 2));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= mrelbp_pkg::CTRL_IDLE;
            col_q       <= '0;
            row_q       <= '0;
            clear_o     <= 1'b0;
            accum_o     <= 1'b0;
            center_o    <= 1'b0;
            row_done_o  <= 1'b0;
            end_pend_q  <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            clear_o     <= win_valid_i && (state_q == mrelbp_pkg::CTRL_IDLE);
            accum_o     <= win_valid_i;
            center_o    <= win_valid_i && at_center;
            row_done_o  <= win_valid_i && last_col;
            end_pend_q  <= win_valid_i && last_win;
            frame_end_o <= end_pend_q;   // lanes hold the full frame by now.
            if (win_valid_i) begin
                if (last_col) begin
                    col_q <= '0;
                    row_q <= last_row ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
                state_q <= last_win ? mrelbp_pkg::CTRL_IDLE : mrelbp_pkg::CTRL_ACCUM;
            end
        end
    end

    // a finished frame must not pick up an add from the next one; only its
    // window 0 may be in flight, and that one reloads the lanes.
    a_frame_end_clean: assert property (@(posedge clk) disable iff (rst)
        frame_end_o |-> $past(row_done_o) && (!accum_o || clear_o))
        else $error("frame end overlaps a non-clearing accumulate");

endmodule

`default_nettype wire

//--- hdl/tap_accumulator.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module tap_accumulator (
    input  wire                        clk,
    input  wire                        rst,
    input  logic                       clear_i,
    input  logic                       accum_i,
    input  logic [`MRELBP_PIX_W-1:0]   tap_i,
    output logic [`MRELBP_LANE_W-1:0]  lane_sum_o
);

    localparam int LANE_W = `MRELBP_LANE_W;

    logic [LANE_W:0] sum_ext;   // one spare bit for the overflow check.

    assign sum_ext = {1'b0, lane_sum_o} + tap_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_sum_o <= '0;
        end else if (accum_i) begin
            if (clear_i) begin
                lane_sum_o <= LANE_W'(tap_i);   // window 0 restarts the lane.
            end else begin
                lane_sum_o <= sum_ext[LANE_W-1:0];
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (accum_i && !clear_i) |-> !sum_ext[LANE_W])
        else $error("lane sum overflow");

endmodule

`default_nettype wire

//--- hdl/lane_reducer.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module lane_reducer (
    input  wire                        clk,
    input  wire                        rst,
    input  logic                       frame_end_i,
    input  logic [`MRELBP_LANE_W-1:0]  lane_sum_i [`MRELBP_TAPS],
    output logic [`MRELBP_SUM_W-1:0]   total_o,
    output logic                       sum_valid_o
);

    localparam int TAPS   = `MRELBP_TAPS;
    localparam int LANE_W = `MRELBP_LANE_W;
    localparam int SUM_W  = `MRELBP_SUM_W;

    logic [SUM_W-1:0] lane_total;

    // plain adder chain, one full cycle is available before frame_end.
    always_comb begin
        lane_total = '0;
        for (int i = 0; i < TAPS; i++) begin
            lane_total = lane_total + {{(SUM_W - LANE_W){1'b0}}, lane_sum_i[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end_i) begin
            total_o <= lane_total;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= frame_end_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mean_divider.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module mean_divider (
    input  wire                       clk,
    input  wire                       rst,
    input  logic                      start_i,
    input  logic [`MRELBP_SUM_W-1:0]  total_i,
    output mrelbp_pkg::mean_t         mean_o,
    output logic                      done_o
);

    localparam int SUM_W = `MRELBP_SUM_W;
    localparam int REM_W = `MRELBP_REM_W;
    localparam int PIX_W = `MRELBP_PIX_W;
    localparam int CNT_W = $clog2(SUM_W);

    localparam logic [REM_W:0] DIVISOR = `MRELBP_DIVISOR;

    mrelbp_pkg::div_state_e state_q;

    logic [CNT_W-1:0] cnt_q;
    logic [SUM_W-1:0] dvd_q;   // dividend, msb first.
    logic [SUM_W-1:0] quo_q;
    logic [REM_W-1:0] rem_q;
    logic [REM_W:0]   trial;
    logic [REM_W:0]   diff;
    logic             fits;
    logic [REM_W-1:0] rem_next;
    logic [SUM_W-1:0] quo_next;
    logic             last_bit;

    // one restoring step; the partial remainder stays below the divisor.
    assign trial    = {rem_q, dvd_q[SUM_W-1]};
    assign diff     = trial - DIVISOR;
    assign fits     = (trial >= DIVISOR);
    assign rem_next = fits ? diff[REM_W-1:0] : trial[REM_W-1:0];
    assign quo_next = {quo_q[SUM_W-2:0], fits};
    assign last_bit = (cnt_q == '0);

    assign done_o = (state_q == mrelbp_pkg::DIV_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mrelbp_pkg::DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                mrelbp_pkg::DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= mrelbp_pkg::DIV_SHIFT;
                        cnt_q   <= CNT_W'(SUM_W - 1);
                    end
                end
                mrelbp_pkg::DIV_SHIFT: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (last_bit) begin
                        state_q <= mrelbp_pkg::DIV_DONE;
                    end
                end
                default: begin
                    state_q <= mrelbp_pkg::DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mrelbp_pkg::DIV_IDLE && start_i) begin
            dvd_q <= total_i;
            quo_q <= '0;
            rem_q <= '0;
        end else if (state_q == mrelbp_pkg::DIV_SHIFT) begin
            dvd_q <= dvd_q << 1;
            quo_q <= quo_next;
            rem_q <= rem_next;
            if (last_bit) begin
                mean_o.muy <= quo_next[PIX_W-1:0];   // result held until next done.
                mean_o.r   <= rem_next;
            end
        end
    end

    // a frame lasts far longer than a division, so no start is ever dropped.
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start_i |-> state_q == mrelbp_pkg::DIV_IDLE)
        else $error("divider started while busy");

    a_quo_fits: assert property (@(posedge clk) disable iff (rst)
        done_o |-> quo_q[SUM_W-1:PIX_W] == '0)
        else $error("mean does not fit in a pixel");

endmodule

`default_nettype wire

//--- hdl/mrelbp_ci_r8.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module mrelbp_ci_r8 (
    input  wire                  clk,
    input  wire                  rst,
    input  mrelbp_pkg::window_t  win_i,
    input  logic                 win_valid_i,
    output logic                 ci_o,
    output logic                 done_o,
    output logic                 progress_done_o
);

    localparam int TAPS   = `MRELBP_TAPS;
    localparam int PIX_W  = `MRELBP_PIX_W;
    localparam int LANE_W = `MRELBP_LANE_W;
    localparam int SUM_W  = `MRELBP_SUM_W;

    mrelbp_pkg::window_t win_q;
    mrelbp_pkg::mean_t   mean;

    logic              clear;
    logic              accum;
    logic              center;
    logic              row_done;
    logic              frame_end;
    logic [LANE_W-1:0] lane_sum [TAPS];
    logic [SUM_W-1:0]  total;
    logic              sum_valid;
    logic              div_done;
    logic [PIX_W-1:0]  center_q;
    logic              ci_next;

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            win_q <= win_i;
        end
        if (center) begin
            center_q <= win_q.taps[`MRELBP_CENTER_TAP];   // middle window's pixel.
        end
    end

    ci_frame_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .win_valid_i (win_valid_i),
        .clear_o     (clear),
        .accum_o     (accum),
        .center_o    (center),
        .row_done_o  (row_done),
        .frame_end_o (frame_end)
    );

    for (genvar g = 0; g < TAPS; g++) begin : g_lane
        tap_accumulator lane_i (
            .clk        (clk),
            .rst        (rst),
            .clear_i    (clear),
            .accum_i    (accum),
            .tap_i      (win_q.taps[g]),
            .lane_sum_o (lane_sum[g])
        );
    end

    lane_reducer reduce_i (
        .clk         (clk),
        .rst         (rst),
        .frame_end_i (frame_end),
        .lane_sum_i  (lane_sum),
        .total_o     (total),
        .sum_valid_o (sum_valid)
    );

    mean_divider div_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (sum_valid),
        .total_i (total),
        .mean_o  (mean),
        .done_o  (div_done)
    );

    // equal counts as set only for an exact mean.
    assign ci_next = (center_q > mean.muy) || (center_q == mean.muy && mean.r == '0);

    assign progress_done_o = row_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_o <= 1'b0;
            ci_o   <= 1'b0;
        end else begin
            done_o <= div_done;
            if (div_done) begin
                ci_o <= ci_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_mrelbp_ci_r8.sv
`default_nettype none

`include "mrelbp_cfg.svh"

module tb_mrelbp_ci_r8;

    localparam int TAPS       = `MRELBP_TAPS;
    localparam int COLS       = `MRELBP_COLS;
    localparam int ROWS       = `MRELBP_ROWS;
    localparam int WINDOWS    = ROWS * COLS;
    localparam int DIVISOR    = `MRELBP_DIVISOR;
    localparam int CENTER_WIN = (ROWS / 2) * COLS + COLS / 2;
    localparam int LATENCY    = 26;   // last strobe to done_o.
    localparam int MAX_GAP    = 16;
    localparam int TIMEOUT    = 200;

    typedef enum logic [1:0] {FILL_CONST, FILL_RANDOM, FILL_RAMP} fill_e;

    typedef struct packed {
        fill_e      mode;
        logic [7:0] base;
        logic       ovr_en;      // replace the middle window's center tap.
        logic [7:0] ovr;
        logic [6:0] gap_pct;
        logic       wait_done;   // 0 starts the next frame back to back.
    } frame_cfg_t;

    logic                clk;
    logic                rst;
    mrelbp_pkg::window_t win_i;
    logic                win_valid_i;
    logic                ci_o;
    logic                done_o;
    logic                progress_done_o;

    frame_cfg_t tests[$];
    logic       exp_ci_q[$];
    int         exp_idx_q[$];
    int         exp_tot_q[$];
    int         last_cyc_q[$];

    integer seed = 32'h701b_0785;
    int     errors = 0;
    int     err_mark = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     frames_done = 0;
    logic   timed_out = 1'b0;

    int   cyc = 0;
    int   win_cnt = 0;
    int   rows_seen = 0;
    int   lat;
    int   idx;
    int   tot;
    logic exp_ci;
    logic row_last_prev = 1'b0;
    logic frame_last_prev = 1'b0;

    mrelbp_ci_r8 dut_i (
        .clk             (clk),
        .rst             (rst),
        .win_i           (win_i),
        .win_valid_i     (win_valid_i),
        .ci_o            (ci_o),
        .done_o          (done_o),
        .progress_done_o (progress_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_pct();
        int v;
        v = $random(seed);
        return (v & 32'h7fff_ffff) % 100;
    endfunction

    function automatic string mode_name(input fill_e m);
        case (m)
            FILL_CONST:  return "const";
            FILL_RANDOM: return "random";
            default:     return "ramp";
        endcase
    endfunction

    task automatic add_test(input fill_e mode, input int base, input logic ovr_en,
                            input int ovr, input int gap, input logic wait_done);
        frame_cfg_t c;
        c.mode      = mode;
        c.base      = 8'(base);
        c.ovr_en    = ovr_en;
        c.ovr       = 8'(ovr);
        c.gap_pct   = 7'(gap);
        c.wait_done = wait_done;
        tests.push_back(c);
    endtask

    task automatic send_frame(input frame_cfg_t cfg, input int num);
        mrelbp_pkg::window_t win;
        int          gaps;
        int          r;
        int          total;
        int          muy;
        int          rem;
        logic [7:0]  pix;
        logic [7:0]  center;
        total  = 0;
        center = 8'd0;
        for (int w = 0; w < WINDOWS; w++) begin
            gaps = 0;
            while (cfg.gap_pct != 0 && gaps < MAX_GAP && rand_pct() < int'(cfg.gap_pct)) begin
                @(posedge clk);
                win_valid_i <= 1'b0;
                gaps++;
            end
            for (int t = 0; t < TAPS; t++) begin
                r = $random(seed);
                case (cfg.mode)
                    FILL_CONST:  pix = cfg.base;
                    FILL_RANDOM: pix = r[7:0];
                    default:     pix = 8'(int'(cfg.base) + w * TAPS + t);
                endcase
                if (cfg.ovr_en && w == CENTER_WIN && t == `MRELBP_CENTER_TAP) begin
                    pix = cfg.ovr;
                end
                win.taps[t] = pix;
                total += pix;
            end
            if (w == CENTER_WIN) begin
                center = win.taps[`MRELBP_CENTER_TAP];
            end
            @(posedge clk);
            win_i       <= win;
            win_valid_i <= 1'b1;
        end
        muy = total / DIVISOR;
        rem = total % DIVISOR;
        exp_ci_q.push_back((center > muy) || (center == muy && rem == 0));
        exp_idx_q.push_back(num);
        exp_tot_q.push_back(total);
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        @(posedge clk);
        win_valid_i <= 1'b0;
        while (frames_done < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (frames_done < target) begin
            $display("timeout: only %0d of %0d frame results arrived after %0d cycles",
                     frames_done, target, n);
            timed_out = 1'b1;
        end
    endtask

    // sampled at the edge, so every value seen belongs to the cycle just ended.
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst) begin
            win_cnt         = 0;
            rows_seen       = 0;
            row_last_prev   = 1'b0;
            frame_last_prev = 1'b0;
        end else begin
            if (progress_done_o !== row_last_prev) begin
                $display("[ERROR] %0t: progress_done_o is %b, expected %b",
                         $time, progress_done_o, row_last_prev);
                errors++;
            end
            if (progress_done_o === 1'b1) begin
                rows_seen++;
                if (frame_last_prev) begin
                    if (rows_seen != ROWS) begin
                        $display("[ERROR] %0t: %0d row pulses in a frame, expected %0d",
                                 $time, rows_seen, ROWS);
                        errors++;
                    end
                    rows_seen = 0;
                end
            end
            if (done_o === 1'b1) begin
                if (exp_ci_q.size() == 0 || last_cyc_q.size() == 0) begin
                    $display("[ERROR] %0t: done_o pulsed with no frame pending", $time);
                    errors++;
                end else begin
                    exp_ci = exp_ci_q.pop_front();
                    idx    = exp_idx_q.pop_front();
                    tot    = exp_tot_q.pop_front();
                    lat    = cyc - last_cyc_q.pop_front();
                    if (lat != LATENCY) begin
                        $display("[ERROR] %0t: done_o came %0d cycles after the last window",
                                 $time, lat);
                        errors++;
                    end
                    if (ci_o !== exp_ci) begin
                        $display("[ERROR] %0t: ci_o is %b, expected %b", $time, ci_o, exp_ci);
                        errors++;
                    end
                    frames_done++;
                    if (errors == err_mark) begin
                        pass_cnt++;
                        $display("frame %0d %s: total %0d muy %0d r %0d ci %b ok", idx,
                                 mode_name(tests[idx].mode), tot, tot / DIVISOR,
                                 tot % DIVISOR, exp_ci);
                    end else begin
                        fail_cnt++;
                        $display("frame %0d %s: FAILED", idx, mode_name(tests[idx].mode));
                    end
                    err_mark = errors;
                end
            end else if (frames_done == 0 && ci_o !== 1'b0) begin
                $display("[ERROR] %0t: ci_o is %b before the first frame", $time, ci_o);
                errors++;
            end
            row_last_prev   = 1'b0;
            frame_last_prev = 1'b0;
            if (win_valid_i === 1'b1) begin
                row_last_prev   = (win_cnt % COLS == COLS - 1);
                frame_last_prev = (win_cnt == WINDOWS - 1);
                if (frame_last_prev) begin
                    last_cyc_q.push_back(cyc);
                    win_cnt = 0;
                end else begin
                    win_cnt++;
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        win_i       = '0;
        win_valid_i = 1'b0;
        add_test(FILL_CONST,  100, 1'b0,   0,  0, 1'b1);
        add_test(FILL_CONST,  100, 1'b1,  99,  0, 1'b1);
        add_test(FILL_CONST,  100, 1'b1, 101,  0, 1'b1);
        add_test(FILL_CONST,    0, 1'b0,   0,  0, 1'b1);
        add_test(FILL_CONST,  255, 1'b1, 254, 30, 1'b1);
        add_test(FILL_RANDOM,   0, 1'b0,   0,  0, 1'b1);
        add_test(FILL_RANDOM,   0, 1'b0,   0,  0, 1'b0);
        add_test(FILL_RANDOM,   0, 1'b0,   0, 70, 1'b0);
        add_test(FILL_RAMP,     5, 1'b0,   0,  0, 1'b0);
        add_test(FILL_RAMP,     5, 1'b0,   0, 80, 1'b1);
        add_test(FILL_CONST,   17, 1'b0,   0, 50, 1'b0);
        add_test(FILL_RANDOM,   0, 1'b1, 128,  0, 1'b1);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (12) @(posedge clk);   // outputs must stay low while idle.
        for (int i = 0; i < tests.size() && !timed_out; i++) begin
            send_frame(tests[i], i);
            if (tests[i].wait_done) begin
                wait_results(i + 1);
            end
        end
        if (!timed_out) begin
            wait_results(tests.size());
        end
        $display("%0d frames checked: %0d ok, %0d bad, %0d errors",
                 frames_done, pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0 && !timed_out && frames_done == tests.size()) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mrelbp_ci_r8.f
+incdir+hdl
hdl/mrelbp_pkg.sv
hdl/ci_frame_ctrl.sv
hdl/tap_accumulator.sv
hdl/lane_reducer.sv
hdl/mean_divider.sv
hdl/mrelbp_ci_r8.sv
tb/tb_mrelbp_ci_r8.sv
